//--- src/ppu_pkg.sv
// ******************************
// Shared sizes, VRAM layout, register map and types of the tile PPU
// Built for one configuration only: 64x64 screen, 8x8 tiles, 4 palettes
// VRAM word addresses, 256 words of 16 bits
// ******************************

package ppu_pkg;

    // Sizes
    localparam int VRAM_AW  = 8;   // 256 VRAM words
    localparam int VRAM_DW  = 16;
    localparam int SCREEN_W = 64;  // Width and height in pixels
    localparam int ROW_AW   = 6;   // Row RAM address
    localparam int PIX_W    = 4;   // {palette, colour index}
    localparam int COLOR_W  = 12;
    localparam int PAL_AW   = 4;   // 16 palette colours
    localparam int SCROLL_W = 6;

    // VRAM regions
    localparam logic [VRAM_AW-1:0] MAP_BASE = 8'h00;  // 8x8 map entries
    localparam logic [VRAM_AW-1:0] PAT_BASE = 8'h40;  // 16 tiles x 8 rows
    localparam logic [VRAM_AW-1:0] PAL_BASE = 8'hC0;  // 4 palettes x 4 colours

    // Control registers
    localparam int REG_AW = 2;
    localparam logic [REG_AW-1:0] REG_HSCROLL = 2'd0;
    localparam logic [REG_AW-1:0] REG_VSCROLL = 2'd1;
    localparam logic [REG_AW-1:0] REG_COMMIT  = 2'd2;  // Bit 0 marks the frame ready

    // One VRAM word, seen as map entry or as pattern row
    typedef union packed {
        struct packed {
            logic [1:0] palette;
            logic [9:0] unused;
            logic [3:0] tile;
        } map;
        logic [0:7][1:0] px;  // px[0] is the leftmost pixel, in the top pair
    } vram_word_u;

    // Frame controller states
    typedef enum logic [1:0] {
        SYNC,  // CPU bank being copied into PPU bank
        DISP,  // Renderer owns PPU bank, CPU owns its own bank
        LATE   // No commit in time, old picture kept
    } ppu_state_e;

endpackage : ppu_pkg

//--- src/vram_if.sv
// ******************************
// VRAM access port, one per bank user
// Read data returns one cycle after the address
// The user side drives address and write strobes
// ******************************

interface vram_if;
    import ppu_pkg::*;

    logic [VRAM_AW-1:0] addr;
    logic               wren;
    logic [VRAM_DW-1:0] wrdata;
    logic [VRAM_DW-1:0] rddata;  // Registered in the bank

    modport user (
        output addr,
        output wren,
        output wrdata,
        input  rddata
    );

    modport mem (
        input  addr,
        input  wren,
        input  wrdata,
        output rddata
    );

endinterface : vram_if

//--- src/vram_bank.sv
// ******************************
// One 256x16 VRAM bank, no reset on contents
// Bus port: write and registered read share one address
// Second read port covers only the palette region
// Read during write returns the old word
// ******************************

module vram_bank (
    input  logic                         clk,
    vram_if.mem                          bus,
    input  logic [ppu_pkg::PAL_AW-1:0]   pal_rdaddr,
    output logic [ppu_pkg::COLOR_W-1:0]  pal_rddata
);
    import ppu_pkg::*;

    logic [VRAM_DW-1:0] mem [2**VRAM_AW];
    logic [VRAM_AW-1:0] pal_addr;

    // Palette index offset into the palette region
    assign pal_addr = PAL_BASE + VRAM_AW'(pal_rdaddr);

    // Shared read/write port
    always_ff @(posedge clk) begin
        if (bus.wren) begin
            mem[bus.addr] <= bus.wrdata;
        end
        bus.rddata <= mem[bus.addr];
    end

    // Colour sits in the low bits of a palette word
    always_ff @(posedge clk) begin
        pal_rddata <= mem[pal_addr][COLOR_W-1:0];
    end

endmodule : vram_bank

//--- src/vram_sync_writer.sv
// ******************************
// Copies all 256 words of the CPU bank into the PPU bank
// Starts on a one-cycle sync_start pulse, busy rises on the next cycle
// Read of word n overlaps the write of word n-1, so busy lasts 257 cycles
// A new sync_start while busy is not allowed
// ******************************

module vram_sync_writer (
    input  logic clk,
    input  logic rst_n,
    input  logic sync_start,
    output logic busy,
    vram_if.user src_bus,
    vram_if.user dst_bus
);
    import ppu_pkg::*;

    logic [VRAM_AW:0] cnt;  // One extra bit for the final write cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (sync_start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            if (cnt == (VRAM_AW+1)'(2**VRAM_AW)) begin
                busy <= 1'b0;  // Last word written this cycle
                cnt  <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Source side only reads
    assign src_bus.addr   = cnt[VRAM_AW-1:0];
    assign src_bus.wren   = 1'b0;
    assign src_bus.wrdata = '0;

    // Destination lags the source by one cycle
    assign dst_bus.addr   = VRAM_AW'(cnt - 1'b1);
    assign dst_bus.wren   = busy && (cnt != '0);
    assign dst_bus.wrdata = src_bus.rddata;  // Word read last cycle

    // Copy may not be restarted halfway
    a_no_restart : assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |-> !sync_start
    );

endmodule : vram_sync_writer

//--- src/vram_interconnect.sv
// ******************************
// Bank ownership switch, purely combinational
// During a copy: CPU writes dropped, renderer reads zero
// Otherwise CPU strobes own the CPU bank, renderer owns the PPU bank
// ******************************

module vram_interconnect (
    input  logic                         sync_active,
    input  logic                         cpu_wren,
    input  logic [ppu_pkg::VRAM_AW-1:0]  cpu_wraddr,
    input  logic [ppu_pkg::VRAM_DW-1:0]  cpu_wrdata,
    vram_if.user                         cpu_bus,
    vram_if.user                         ppu_bus,
    vram_if.mem                          vsw_c_bus,
    vram_if.mem                          vsw_p_bus,
    vram_if.mem                          ren_bus
);

    always_comb begin
        if (sync_active) begin
            // Sync writer reads the CPU bank
            cpu_bus.addr       = vsw_c_bus.addr;
            cpu_bus.wren       = vsw_c_bus.wren;
            cpu_bus.wrdata     = vsw_c_bus.wrdata;
            vsw_c_bus.rddata   = cpu_bus.rddata;
            // Sync writer fills the PPU bank
            ppu_bus.addr       = vsw_p_bus.addr;
            ppu_bus.wren       = vsw_p_bus.wren;
            ppu_bus.wrdata     = vsw_p_bus.wrdata;
            vsw_p_bus.rddata   = ppu_bus.rddata;
            ren_bus.rddata     = '0;  // Renderer sees blank words
        end else begin
            // CPU has write-only access
            cpu_bus.addr       = cpu_wraddr;
            cpu_bus.wren       = cpu_wren;
            cpu_bus.wrdata     = cpu_wrdata;
            vsw_c_bus.rddata   = '0;
            // Renderer reads the PPU bank
            ppu_bus.addr       = ren_bus.addr;
            ppu_bus.wren       = ren_bus.wren;
            ppu_bus.wrdata     = ren_bus.wrdata;
            ren_bus.rddata     = ppu_bus.rddata;
            vsw_p_bus.rddata   = '0;
        end
    end

endmodule : vram_interconnect

//--- src/ppu_ctrl_regs.sv
// ******************************
// Scroll registers and frame commit flag
// Scroll writes land in shadows, live values load on sync_start
// Commit (bit 0 of REG_COMMIT) holds until the next sync_start
// sync_start wins over a commit in the same cycle
// ******************************

module ppu_ctrl_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          reg_wren,
    input  logic [ppu_pkg::REG_AW-1:0]    reg_addr,
    input  logic [ppu_pkg::SCROLL_W-1:0]  reg_wrdata,
    input  logic                          sync_start,
    output logic [ppu_pkg::SCROLL_W-1:0]  hscroll,
    output logic [ppu_pkg::SCROLL_W-1:0]  vscroll,
    output logic                          frame_ready
);
    import ppu_pkg::*;

    logic [SCROLL_W-1:0] shadow_h;
    logic [SCROLL_W-1:0] shadow_v;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shadow_h    <= '0;
            shadow_v    <= '0;
            hscroll     <= '0;
            vscroll     <= '0;
            frame_ready <= 1'b0;
        end else begin
            if (reg_wren) begin
                case (reg_addr)
                    REG_HSCROLL: shadow_h <= reg_wrdata;
                    REG_VSCROLL: shadow_v <= reg_wrdata;
                    REG_COMMIT:  if (reg_wrdata[0]) frame_ready <= 1'b1;
                    default: ;  // Unmapped address ignored
                endcase
            end
            if (sync_start) begin
                hscroll     <= shadow_h;  // Takes effect with the new copy
                vscroll     <= shadow_v;
                frame_ready <= 1'b0;      // Frame consumed by the copy
            end
        end
    end

endmodule : ppu_ctrl_regs

//--- src/row_renderer.sv
// ******************************
// Renders one scrolled screen row into the back row buffer
// Swap flips buffers and restarts rendering of next_row
// 16 VRAM reads, map then pattern per tile column, done in 17 cycles
// Video reads only the front buffer, one cycle after the address
// ******************************

module row_renderer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rowram_swap,
    input  logic [ppu_pkg::ROW_AW-1:0]    next_row,
    input  logic [ppu_pkg::SCROLL_W-1:0]  hscroll,
    input  logic [ppu_pkg::SCROLL_W-1:0]  vscroll,
    vram_if.user                          ren_bus,
    input  logic [ppu_pkg::ROW_AW-1:0]    hdmi_rowram_rdaddr,
    output logic [ppu_pkg::PIX_W-1:0]     hdmi_rowram_rddata
);
    import ppu_pkg::*;

    logic [PIX_W-1:0]    row_mem [2][SCREEN_W];  // Double-buffered row RAM
    logic                front_sel;
    logic                active;
    logic [4:0]          step;       // Even: map read, odd: pattern read
    logic [ROW_AW-1:0]   src_row;    // Scrolled source row
    logic [SCROLL_W-1:0] h_q;        // hscroll for this render
    logic [1:0]          pal_q;      // Palette of the current tile
    vram_word_u          rd_word;
    logic [2:0]          col;
    logic [2:0]          wr_col;
    logic                pix_wr;
    logic [ROW_AW-1:0]   dst_addr [8];

    assign rd_word = ren_bus.rddata;
    assign col     = step[3:1];
    assign wr_col  = col - 3'd1;  // Pattern data belongs to the previous pair

    // Pattern word arrives on even steps after the first
    assign pix_wr = active && !step[0] && (step != 5'd0) && !rowram_swap;

    // Renderer never writes VRAM
    assign ren_bus.wren   = 1'b0;
    assign ren_bus.wrdata = '0;

    always_comb begin
        if (step[0]) begin
            // Tile index comes straight from the map word just returned
            ren_bus.addr = PAT_BASE + VRAM_AW'({rd_word.map.tile, src_row[2:0]});
        end else begin
            ren_bus.addr = MAP_BASE + VRAM_AW'({src_row[5:3], col});  // Tile row x 8 + col
        end
    end

    // Destination of each pixel after horizontal scroll, wraps mod 64
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            dst_addr[i] = {wr_col, 3'(i)} - h_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            front_sel <= 1'b0;
            active    <= 1'b0;
            step      <= '0;
        end else if (rowram_swap) begin
            front_sel <= ~front_sel;  // Restarts any render in progress
            active    <= 1'b1;
            step      <= '0;
        end else if (active) begin
            if (step == 5'd16) begin
                active <= 1'b0;  // Last pattern row written
                step   <= '0;
            end else begin
                step <= step + 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rowram_swap) begin
            src_row <= next_row + vscroll;
            h_q     <= hscroll;
        end
        if (active && step[0]) begin
            pal_q <= rd_word.map.palette;
        end
    end

    // Eight pixels per pattern word into the back buffer
    always_ff @(posedge clk) begin
        if (pix_wr) begin
            for (int i = 0; i < 8; i++) begin
                row_mem[~front_sel][dst_addr[i]] <= {pal_q, rd_word.px[i]};
            end
        end
        hdmi_rowram_rddata <= row_mem[front_sel][hdmi_rowram_rdaddr];
    end

endmodule : row_renderer

//--- src/ppu.sv
// ******************************
// Tile PPU top level with the frame controller
// Starts in LATE, first committed frame is needed for a picture
// vblank_start to vblank_end_soon must be at least 260 cycles
// Swaps pass only in DISP, CPU writes during a copy are lost
// ******************************

module ppu (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_wren,
    input  logic [ppu_pkg::VRAM_AW-1:0]   cpu_wraddr,
    input  logic [ppu_pkg::VRAM_DW-1:0]   cpu_wrdata,
    input  logic                          reg_wren,
    input  logic [ppu_pkg::REG_AW-1:0]    reg_addr,
    input  logic [ppu_pkg::SCROLL_W-1:0]  reg_wrdata,
    input  logic [ppu_pkg::ROW_AW-1:0]    hdmi_rowram_rdaddr,
    output logic [ppu_pkg::PIX_W-1:0]     hdmi_rowram_rddata,
    input  logic [ppu_pkg::PAL_AW-1:0]    hdmi_palram_rdaddr,
    output logic [ppu_pkg::COLOR_W-1:0]   hdmi_palram_rddata,
    input  logic                          rowram_swap,
    input  logic [ppu_pkg::ROW_AW-1:0]    next_row,
    input  logic                          vblank_start,
    input  logic                          vblank_end_soon,
    output logic                          ppu_late
);
    import ppu_pkg::*;

    ppu_state_e          state, next_state;
    logic                sync_start;
    logic                sync_busy;   // Copy running, banks owned by sync writer
    logic                frame_ready;
    logic                rowram_swap_disp;
    logic [SCROLL_W-1:0] hscroll;
    logic [SCROLL_W-1:0] vscroll;

    vram_if cpu_bus ();    // CPU-facing bank
    vram_if ppu_bus ();    // PPU-facing bank
    vram_if vsw_c_bus ();  // Sync writer source
    vram_if vsw_p_bus ();  // Sync writer destination
    vram_if ren_bus ();    // Renderer reads

    vram_bank cpu_bank (
        .clk,
        .bus        (cpu_bus.mem),
        .pal_rdaddr ('0),  // Palette port idle on this bank
        .pal_rddata ()
    );

    vram_bank ppu_bank (
        .clk,
        .bus        (ppu_bus.mem),
        .pal_rdaddr (hdmi_palram_rdaddr),
        .pal_rddata (hdmi_palram_rddata)
    );

    vram_sync_writer vsw (
        .clk,
        .rst_n,
        .sync_start,
        .busy    (sync_busy),
        .src_bus (vsw_c_bus.user),
        .dst_bus (vsw_p_bus.user)
    );

    vram_interconnect vi (
        .sync_active (sync_busy),
        .cpu_wren,
        .cpu_wraddr,
        .cpu_wrdata,
        .cpu_bus     (cpu_bus.user),
        .ppu_bus     (ppu_bus.user),
        .vsw_c_bus   (vsw_c_bus.mem),
        .vsw_p_bus   (vsw_p_bus.mem),
        .ren_bus     (ren_bus.mem)
    );

    ppu_ctrl_regs regs (
        .clk,
        .rst_n,
        .reg_wren,
        .reg_addr,
        .reg_wrdata,
        .sync_start,
        .hscroll,
        .vscroll,
        .frame_ready
    );

    row_renderer ren (
        .clk,
        .rst_n,
        .rowram_swap (rowram_swap_disp),
        .next_row,
        .hscroll,
        .vscroll,
        .ren_bus     (ren_bus.user),
        .hdmi_rowram_rdaddr,
        .hdmi_rowram_rddata
    );

    // Copy only a committed frame
    assign sync_start       = (state == DISP) && vblank_start && frame_ready;
    assign rowram_swap_disp = (state == DISP) && rowram_swap;  // Swaps ignored outside DISP
    assign ppu_late         = (state == LATE);

    always_comb begin
        next_state = state;
        case (state)
            DISP: begin
                if (vblank_start) begin
                    next_state = frame_ready ? SYNC : LATE;
                end
            end
            SYNC, LATE: begin
                if (vblank_end_soon) next_state = DISP;
            end
            default: next_state = LATE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LATE;  // No picture until the first commit
        end else begin
            state <= next_state;
        end
    end

    // Vblank must outlast the copy
    a_copy_done : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == SYNC) && (next_state != SYNC) |-> !sync_busy
    );

endmodule : ppu

//--- verification/tb_ppu.sv
// ******************************
// Self-checking testbench for the tile PPU
// Table steps run in order, a reference model gives expected pixels
// Row checks are valid only after two swaps in DISP fill both buffers
// Stops at the first mismatch or timeout
// ******************************

module tb_ppu;
    import ppu_pkg::*;

    localparam int OP_VRAM    = 0;  // Single VRAM write, a = address, b = data
    localparam int OP_REG     = 1;  // Register write, a = address, b = data
    localparam int OP_FILL    = 2;  // Whole CPU bank from $random
    localparam int OP_VBSTART = 3;  // vblank_start, then hold vblank
    localparam int OP_VBEND   = 4;  // vblank_end_soon
    localparam int OP_SWAP    = 5;  // a = next_row
    localparam int OP_SNAP    = 6;  // Capture the front row as reference
    localparam int OP_ROWCHK  = 7;
    localparam int OP_PALCHK  = 8;
    localparam int OP_LATE    = 9;  // exp = ppu_late
    localparam int SWAP_WAIT     = 24;
    localparam int VBLANK_CYCLES = 300;
    localparam int SETTLE_LIMIT  = 4;

    logic                clk;
    logic                rst_n;
    logic                cpu_wren;
    logic [VRAM_AW-1:0]  cpu_wraddr;
    logic [VRAM_DW-1:0]  cpu_wrdata;
    logic                reg_wren;
    logic [REG_AW-1:0]   reg_addr;
    logic [SCROLL_W-1:0] reg_wrdata;
    logic [ROW_AW-1:0]   hdmi_rowram_rdaddr;
    logic [PIX_W-1:0]    hdmi_rowram_rddata;
    logic [PAL_AW-1:0]   hdmi_palram_rdaddr;
    logic [COLOR_W-1:0]  hdmi_palram_rddata;
    logic                rowram_swap;
    logic [ROW_AW-1:0]   next_row;
    logic                vblank_start;
    logic                vblank_end_soon;
    logic                ppu_late;

    // Stimulus table, one entry per step
    string t_name [$];
    int    t_op [$];
    int    t_a [$];
    int    t_b [$];
    int    t_exp [$];

    // Reference model state
    logic [VRAM_DW-1:0] cpu_img [256];         // What the CPU has written
    logic [VRAM_DW-1:0] disp_img [256];        // Last copied image
    logic [PIX_W-1:0]   front_row [SCREEN_W];
    logic [PIX_W-1:0]   back_row [SCREEN_W];
    ppu_state_e         m_state;
    int                 shadow_h;
    int                 shadow_v;
    int                 live_h;
    int                 live_v;
    logic               committed;
    int                 seed = 99232;
    int                 error_count;

    ppu dut0 (.*);

    always #4 clk = ~clk;

    task automatic add_step(input string name, input int op, input int a, input int b,
                            input int exp);
        t_name.push_back(name);
        t_op.push_back(op);
        t_a.push_back(a);
        t_b.push_back(b);
        t_exp.push_back(exp);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    // Poll ppu_late, bounded by limit cycles
    task automatic wait_late(input logic expected, input int limit);
        int n;
        n = 0;
        while (ppu_late !== expected && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (ppu_late !== expected) begin
            $display("Timeout: ppu_late did not reach %0d within %0d cycles", expected, limit);
            $display("Checks failed");
            $fatal(1, "Stopped on timeout");
        end
    endtask

    // Model of one scrolled row into the back buffer
    task automatic render_row(input int row);
        vram_word_u map_w;
        vram_word_u pat_w;
        int         src;
        int         sx;
        src = (row + live_v) % SCREEN_W;
        for (int tc = 0; tc < 8; tc++) begin
            map_w = disp_img[int'(MAP_BASE) + (src / 8) * 8 + tc];
            pat_w = disp_img[int'(PAT_BASE) + int'(map_w.map.tile) * 8 + src % 8];
            for (int x = 0; x < 8; x++) begin
                sx = tc * 8 + x;
                back_row[(sx - live_h + SCREEN_W) % SCREEN_W] = {map_w.map.palette, pat_w.px[x]};
            end
        end
    endtask

    task automatic write_vram(input int addr, input int data);
        cpu_wren   = 1'b1;
        cpu_wraddr = 8'(addr);
        cpu_wrdata = 16'(data);
        @(negedge clk);
        cpu_wren   = 1'b0;
        cpu_img[addr] = 16'(data);
    endtask

    task automatic write_reg(input int addr, input int data);
        reg_wren   = 1'b1;
        reg_addr   = 2'(addr);
        reg_wrdata = 6'(data);
        @(negedge clk);
        reg_wren   = 1'b0;
        if (addr == int'(REG_HSCROLL)) begin
            shadow_h = data % SCREEN_W;
        end else if (addr == int'(REG_VSCROLL)) begin
            shadow_v = data % SCREEN_W;
        end else if (addr == int'(REG_COMMIT) && data % 2 == 1) begin
            committed = 1'b1;
        end
    endtask

    task automatic apply_step(input int k);
        string name;
        name = t_name[k];
        case (t_op[k])
            OP_VRAM: write_vram(t_a[k], t_b[k]);
            OP_REG:  write_reg(t_a[k], t_b[k]);
            OP_FILL: begin
                for (int i = 0; i < 256; i++) begin
                    write_vram(i, $random(seed));
                end
            end
            OP_VBSTART: begin
                vblank_start = 1'b1;
                @(negedge clk);
                vblank_start = 1'b0;
                if (m_state == DISP && committed) begin
                    disp_img  = cpu_img;  // Copy takes the whole CPU bank
                    live_h    = shadow_h;
                    live_v    = shadow_v;
                    committed = 1'b0;
                    m_state   = SYNC;
                end else if (m_state == DISP) begin
                    m_state = LATE;
                end
                wait_late(t_exp[k] != 0, SETTLE_LIMIT);
                wait_cycles(VBLANK_CYCLES);  // Longer than the 257-cycle copy
                check_value(name, 32'(t_exp[k]), 32'(ppu_late));
            end
            OP_VBEND: begin
                vblank_end_soon = 1'b1;
                @(negedge clk);
                vblank_end_soon = 1'b0;
                m_state = DISP;
                check_value(name, 32'(t_exp[k]), 32'(ppu_late));  // State moved on that edge
            end
            OP_SWAP: begin
                rowram_swap = 1'b1;
                next_row    = 6'(t_a[k]);
                @(negedge clk);
                rowram_swap = 1'b0;
                if (m_state == DISP) begin
                    front_row = back_row;  // Previous render becomes visible
                    render_row(t_a[k]);
                end
                wait_cycles(SWAP_WAIT);
            end
            OP_SNAP, OP_ROWCHK: begin
                for (int i = 0; i < SCREEN_W; i++) begin
                    hdmi_rowram_rdaddr = 6'(i);
                    @(negedge clk);  // Data one cycle after the address
                    if (t_op[k] == OP_SNAP) begin
                        front_row[i] = hdmi_rowram_rddata;
                    end else begin
                        check_value($sformatf("%s px %0d", name, i), 32'(front_row[i]),
                                    32'(hdmi_rowram_rddata));
                    end
                end
            end
            OP_PALCHK: begin
                for (int i = 0; i < 16; i++) begin
                    hdmi_palram_rdaddr = 4'(i);
                    @(negedge clk);
                    check_value($sformatf("%s col %0d", name, i),
                                32'(disp_img[int'(PAL_BASE) + i][COLOR_W-1:0]),
                                32'(hdmi_palram_rddata));
                end
            end
            OP_LATE: check_value(name, 32'(t_exp[k]), 32'(ppu_late));
            default: ;
        endcase
    endtask

    task automatic build_table();
        // Reset state, swap before the first display frame
        add_step("reset_late", OP_LATE, 0, 0, 1);
        add_step("reset_snap", OP_SNAP, 0, 0, 0);
        add_step("early_swap", OP_SWAP, 3, 0, 0);
        add_step("first_vbs", OP_VBSTART, 0, 0, 1);
        add_step("first_vbe", OP_VBEND, 0, 0, 0);
        add_step("early_row", OP_ROWCHK, 0, 0, 0);
        // First committed image
        add_step("img1_fill", OP_FILL, 0, 0, 0);
        add_step("img1_commit", OP_REG, int'(REG_COMMIT), 1, 0);
        add_step("img1_vbs", OP_VBSTART, 0, 0, 0);
        add_step("img1_vbe", OP_VBEND, 0, 0, 0);
        add_step("img1_swap0", OP_SWAP, 0, 0, 0);
        add_step("img1_swap1", OP_SWAP, 1, 0, 0);
        add_step("img1_row0", OP_ROWCHK, 0, 0, 0);
        add_step("img1_swap37", OP_SWAP, 37, 0, 0);
        add_step("img1_row1", OP_ROWCHK, 0, 0, 0);
        add_step("img1_swap63", OP_SWAP, 63, 0, 0);
        add_step("img1_row37", OP_ROWCHK, 0, 0, 0);
        add_step("img1_pal", OP_PALCHK, 0, 0, 0);
        // Scroll stays in the shadows until the next copy
        add_step("scroll_h", OP_REG, int'(REG_HSCROLL), 13, 0);
        add_step("scroll_v", OP_REG, int'(REG_VSCROLL), 21, 0);
        add_step("pend_swap6", OP_SWAP, 6, 0, 0);
        add_step("pend_swap7", OP_SWAP, 7, 0, 0);
        add_step("pend_row6", OP_ROWCHK, 0, 0, 0);
        add_step("scroll_commit", OP_REG, int'(REG_COMMIT), 1, 0);
        add_step("scroll_vbs", OP_VBSTART, 0, 0, 0);
        add_step("scroll_vbe", OP_VBEND, 0, 0, 0);
        add_step("scroll_swap8", OP_SWAP, 8, 0, 0);
        add_step("scroll_swap50", OP_SWAP, 50, 0, 0);
        add_step("scroll_row8", OP_ROWCHK, 0, 0, 0);
        add_step("scroll_swap63", OP_SWAP, 63, 0, 0);
        add_step("scroll_row50", OP_ROWCHK, 0, 0, 0);  // Source row wraps past 63
        // New image without a commit gives a late frame
        add_step("img2_fill", OP_FILL, 0, 0, 0);
        add_step("img2_pal5", OP_VRAM, int'(PAL_BASE) + 5, 16'h0F5A, 0);
        add_step("late_vbs", OP_VBSTART, 0, 0, 1);
        add_step("late_swap", OP_SWAP, 9, 0, 0);
        add_step("late_row", OP_ROWCHK, 0, 0, 0);
        add_step("late_vbe", OP_VBEND, 0, 0, 0);
        add_step("old_swap10", OP_SWAP, 10, 0, 0);
        add_step("old_swap11", OP_SWAP, 11, 0, 0);
        add_step("old_row10", OP_ROWCHK, 0, 0, 0);
        add_step("old_pal", OP_PALCHK, 0, 0, 0);
        // Commit brings the second image
        add_step("img2_commit", OP_REG, int'(REG_COMMIT), 1, 0);
        add_step("img2_vbs", OP_VBSTART, 0, 0, 0);
        add_step("img2_vbe", OP_VBEND, 0, 0, 0);
        add_step("img2_swap12", OP_SWAP, 12, 0, 0);
        add_step("img2_swap13", OP_SWAP, 13, 0, 0);
        add_step("img2_row12", OP_ROWCHK, 0, 0, 0);
        add_step("img2_pal", OP_PALCHK, 0, 0, 0);
    endtask

    initial begin
        clk                = 1'b0;
        rst_n              = 1'b0;
        cpu_wren           = 1'b0;
        cpu_wraddr         = '0;
        cpu_wrdata         = '0;
        reg_wren           = 1'b0;
        reg_addr           = '0;
        reg_wrdata         = '0;
        hdmi_rowram_rdaddr = '0;
        hdmi_palram_rdaddr = '0;
        rowram_swap        = 1'b0;
        next_row           = '0;
        vblank_start       = 1'b0;
        vblank_end_soon    = 1'b0;
        m_state            = LATE;  // Controller leaves reset in LATE
        committed          = 1'b0;
        shadow_h           = 0;
        shadow_v           = 0;
        live_h             = 0;
        live_v             = 0;
        error_count        = 0;
        build_table();
        wait_cycles(8);
        rst_n = 1'b1;
        @(negedge clk);
        for (int k = 0; k < t_op.size(); k++) begin
            apply_step(k);
        end
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_ppu

//--- verilog.f
src/ppu_pkg.sv
src/vram_if.sv
src/vram_bank.sv
src/vram_sync_writer.sv
src/vram_interconnect.sv
src/ppu_ctrl_regs.sv
src/row_renderer.sv
src/ppu.sv
verification/tb_ppu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PPU testbench with Verilator, run it, and pass only if the pass line is printed
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 --top-module tb_ppu -f verilog.f \
    && ./obj_dir/Vtb_ppu | tee /dev/stderr | grep -q "All checks passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
